// File: common/zports_cfg.svh
// port addresses, BE readback selectors
// and AY upper address codes

`ifndef ZPORTS_CFG_SVH
`define ZPORTS_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// low address byte of each port
////////////////////////////////////////////////////////////////////////////

`define ZP_PORT_FE     8'hFE // border, beeper, keyboard
`define ZP_PORT_F6     8'hF6 // FE alias, no beeper
`define ZP_PORT_FD     8'hFD // 7FFD paging, AY FFFD/BFFD
`define ZP_PORT_F7     8'hF7 // EFF7 pentagon-1M
`define ZP_PORT_BF     8'hBF // config port
`define ZP_PORT_BE     8'hBE // readback, nmi end
`define ZP_PORT_KJOY   8'h1F // kempston joystick
`define ZP_PORT_KMOUSE 8'hDF // kempston mouse

////////////////////////////////////////////////////////////////////////////
// BE readback index, taken from a[11:8]
////////////////////////////////////////////////////////////////////////////

`define ZP_BE_IDX_7FFD 4'hA
`define ZP_BE_IDX_EFF7 4'hB

////////////////////////////////////////////////////////////////////////////
// AY select by a[15:14] on the FD port
////////////////////////////////////////////////////////////////////////////

`define ZP_AY_HI_REG 2'b11 // FFFD, register select / read
`define ZP_AY_HI_DAT 2'b10 // BFFD, data write

`endif

// File: common/zports_pkg.sv
// shared types for the CPU I/O port block
// 7FFD paging word with field and raw views

package zports_pkg;

	//////////////////////////////////////////////////////////////////////////
	// 7FFD register
	//////////////////////////////////////////////////////////////////////////

	// decoded per field by the pager, read back whole on BE
	typedef struct packed {
		logic [1:0] ext_page; // 1M extension, bits 7..6
		logic       lock48;   // bit 5, 48K lock
		logic       rom;      // bit 4, rom select
		logic       screen;   // bit 3, shadow screen
		logic [2:0] ram_page; // bits 2..0, 128K page
	} p7ffd_fld_t;

	typedef union packed {
		p7ffd_fld_t fld; // field view
		logic [7:0] raw; // byte as written by the CPU
	} p7ffd_t;

endpackage

// File: common/io_bus_if.sv
// decoded CPU I/O bus shared inside the port block
// address halves, data, cycle strobes and shadow mode

`timescale 1ns/1ps

interface io_bus_if;

	logic [7:0] loa;     // a[7:0], port select
	logic [7:0] ahi;     // a[15:8]
	logic [7:0] din;     // cpu data bus
	logic       port_wr; // one cycle, start of io write
	logic       port_rd; // one cycle, start of io read
	logic       shadow;  // dos or shadow enable

	modport strobe (output port_wr, port_rd);

	modport cfg (input loa, ahi, din, port_wr, port_rd, output shadow);

	modport dec (input loa, ahi, din, port_wr, port_rd, shadow);

	modport pager (input loa, ahi, din, port_wr, port_rd, shadow);

endinterface

// File: hw/io_strobe.sv
// io cycle start detector
// one-cycle port_wr / port_rd strobes on zclk

`timescale 1ns/1ps

module io_strobe (
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	io_bus_if.strobe bus
);

	logic iowr_act; // io write level
	logic iord_act; // io read level
	logic iowr_q;   // level seen last edge
	logic iord_q;

	assign iowr_act = ~(iorq_n | wr_n);
	assign iord_act = ~(iorq_n | rd_n);

	// rising edge of the sampled level, held level gives no repeat
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q      <= 1'b0;
			iord_q      <= 1'b0;
			bus.port_wr <= 1'b0;
			bus.port_rd <= 1'b0;
		end
		else
		begin
			iowr_q      <= iowr_act;
			iord_q      <= iord_act;
			bus.port_wr <= iowr_act & ~iowr_q; // first active edge only
			bus.port_rd <= iord_act & ~iord_q;
		end
	end

endmodule

// File: hw/port_decode.sv
// port hit and external port decode
// read enable and read data multiplexer

`timescale 1ns/1ps

`include "zports_cfg.svh"

module port_decode (
	input  logic [15:0]         a,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic [4:0]          keys_in,
	input  logic [4:0]          kj_in,
	input  logic [7:0]          mus_in,
	input  logic                tape_read,
	input  zports_pkg::p7ffd_t  p7ffd_reg,
	input  logic [7:0]          peff7_reg,
	input  logic [7:0]          cfg_rd,
	io_bus_if.dec               bus,
	output logic                porthit,
	output logic                external_port,
	output logic                dataout,
	output logic [7:0]          dout
);

	logic [7:0] be_mux; // BE readback byte

	////////////////////////////////////////////////////////////////////////////
	// hit decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (bus.loa)
			`ZP_PORT_FE, `ZP_PORT_F6, `ZP_PORT_FD,
			`ZP_PORT_KMOUSE, `ZP_PORT_BF, `ZP_PORT_BE:
				porthit = 1'b1;
			`ZP_PORT_KJOY, `ZP_PORT_F7:
				porthit = ~bus.shadow; // joystick and EFF7 hidden in shadow mode
			default:
				porthit = 1'b0;
		endcase
	end

	// FFFD goes to the AY, board drives the bus
	assign external_port = (bus.loa == `ZP_PORT_FD) && (a[15:14] == `ZP_AY_HI_REG);

	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

	////////////////////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (a[11:8])
			`ZP_BE_IDX_7FFD: be_mux = p7ffd_reg.raw; // unmasked register
			`ZP_BE_IDX_EFF7: be_mux = peff7_reg;
			default:         be_mux = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (bus.loa)
			`ZP_PORT_FE, `ZP_PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`ZP_PORT_KJOY:
				dout = {3'b000, kj_in};
			`ZP_PORT_KMOUSE:
				dout = mus_in;
			`ZP_PORT_BF:
				dout = cfg_rd;
			`ZP_PORT_BE:
				dout = be_mux;
			default:
				dout = 8'hFF; // idle bus value
		endcase
	end

endmodule

// File: hw/sys_ports.sv
// FE border and beeper, AY bus control
// BF config register and BE nmi clear

`timescale 1ns/1ps

`include "zports_cfg.svh"

module sys_ports (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic        dos,
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	io_bus_if.cfg       bus,
	output logic [3:0]  border,
	output logic        beeper_wr,
	output logic        ay_bdir,
	output logic        ay_bc1,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic [7:0]  cfg_rd
);

	logic shadow_en; // BF bit 0
	logic fe_wr;     // FE or F6 write
	logic bf_wr;
	logic ay_sel;    // FD port addressed

	assign fe_wr = bus.port_wr & ((bus.loa == `ZP_PORT_FE) | (bus.loa == `ZP_PORT_F6));
	assign bf_wr = bus.port_wr & (bus.loa == `ZP_PORT_BF);

	assign beeper_wr = bus.port_wr & (bus.loa == `ZP_PORT_FE); // F6 is silent
	assign clr_nmi   = bus.port_wr & (bus.loa == `ZP_PORT_BE);

	assign bus.shadow = dos | shadow_en;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border    <= 4'h0;
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else
		begin
			if (fe_wr)
				border <= {~a[3], bus.din[2:0]}; // bright from address bit 3
			if (bf_wr)
			begin
				shadow_en <= bus.din[0];
				romrw_en  <= bus.din[1];
				set_nmi   <= bus.din[3];
			end
		end
	end

	// bit 2 was font write enable, reads zero
	assign cfg_rd = {4'b0000, set_nmi, 1'b0, romrw_en, shadow_en};

	////////////////////////////////////////////////////////////////////////////
	// AY control, straight from the bus
	////////////////////////////////////////////////////////////////////////////

	assign ay_sel = (bus.loa == `ZP_PORT_FD) & ~iorq_n;

	// bc1 alone on FFFD read, bc1+bdir latches address on FFFD write
	assign ay_bc1  = ay_sel & (a[15:14] == `ZP_AY_HI_REG) & (~rd_n | ~wr_n);
	assign ay_bdir = ay_sel & ~wr_n &
		((a[15:14] == `ZP_AY_HI_REG) | (a[15:14] == `ZP_AY_HI_DAT)); // data write on BFFD

endmodule

// File: paging/mem_paging.sv
// 128K 7FFD and pentagon-1M EFF7 paging registers
// 48K lock, 1M masking and page outputs

`timescale 1ns/1ps

`include "zports_cfg.svh"

module mem_paging (
	input  logic               zclk,
	input  logic               rst_n,
	io_bus_if.pager            bus,
	output logic [7:0]         p7ffd,
	output logic [7:0]         peff7,
	output zports_pkg::p7ffd_t p7ffd_reg,
	output logic [7:0]         peff7_reg,
	output logic [5:0]         pent1m_page,
	output logic               pent1m_rom,
	output logic               pent1m_1m_on,
	output logic               pent1m_ram0_0
);

	import zports_pkg::*;

	p7ffd_t     p7ffd_q;
	logic [7:0] peff7_q;
	logic       block1m;   // EFF7 bit 2, back to plain 128K
	logic       block7ffd; // 48K lock holds while 1M is off
	logic       fd_wr;
	logic       f7_wr;

	assign block1m   = peff7_q[2];
	assign block7ffd = p7ffd_q.fld.lock48 & block1m;

	// 7FFD decodes only a15 low
	assign fd_wr = bus.port_wr & (bus.loa == `ZP_PORT_FD) & ~bus.ahi[7] & ~block7ffd;
	// EFF7, bit 8 set and bit 12 clear, not in shadow mode
	assign f7_wr = bus.port_wr & (bus.loa == `ZP_PORT_F7) & bus.ahi[0] & ~bus.ahi[4] &
		~bus.shadow;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= '0;
			peff7_q <= 8'h00;
		end
		else
		begin
			if (fd_wr)
				p7ffd_q.raw <= bus.din;
			if (f7_wr)
				peff7_q <= bus.din;
		end
	end

	// masked views for the rest of the machine
	assign p7ffd = block1m ? {3'b000, p7ffd_q.raw[4:0]} : p7ffd_q.raw;
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign p7ffd_reg = p7ffd_q; // raw copies for BE readback
	assign peff7_reg = peff7_q;

	assign pent1m_page   = {p7ffd_q.fld.ext_page, p7ffd_q.fld.lock48, p7ffd_q.fld.ram_page};
	assign pent1m_rom    = p7ffd_q.fld.rom;
	assign pent1m_1m_on  = ~peff7_q[2];
	assign pent1m_ram0_0 = peff7_q[3]; // ram in rom window

endmodule

// File: hw/zports_top.sv
// CPU I/O port block top level
// strobe, decode, system ports and paging instances

`timescale 1ns/1ps

module zports_top (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        dataout,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic        tape_read,
	output logic        porthit,
	output logic        external_port,
	output logic [3:0]  border,
	output logic        beeper_wr,
	output logic        ay_bdir,
	output logic        ay_bc1,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0
);

	import zports_pkg::*;

	p7ffd_t     p7ffd_reg; // raw registers for readback
	logic [7:0] peff7_reg;
	logic [7:0] cfg_rd;    // BF readback

	io_bus_if bus ();

	assign bus.loa = a[7:0];
	assign bus.ahi = a[15:8];
	assign bus.din = din;

	io_strobe u_strobe (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.bus    (bus.strobe)
	);

	port_decode u_decode (
		.a             (a),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.keys_in       (keys_in),
		.kj_in         (kj_in),
		.mus_in        (mus_in),
		.tape_read     (tape_read),
		.p7ffd_reg     (p7ffd_reg),
		.peff7_reg     (peff7_reg),
		.cfg_rd        (cfg_rd),
		.bus           (bus.dec),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout),
		.dout          (dout)
	);

	sys_ports u_sys (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.dos       (dos),
		.a         (a),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.bus       (bus.cfg),
		.border    (border),
		.beeper_wr (beeper_wr),
		.ay_bdir   (ay_bdir),
		.ay_bc1    (ay_bc1),
		.romrw_en  (romrw_en),
		.set_nmi   (set_nmi),
		.clr_nmi   (clr_nmi),
		.cfg_rd    (cfg_rd)
	);

	mem_paging u_paging (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.bus           (bus.pager),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.p7ffd_reg     (p7ffd_reg),
		.peff7_reg     (peff7_reg),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

endmodule

// File: test/zports_props.sv
// bus protocol and paging lock assertions
// bound into the port block top level

`timescale 1ns/1ps

`include "zports_cfg.svh"

module zports_props (
	input logic        zclk,
	input logic        rst_n,
	input logic [15:0] a,
	input logic        iorq_n,
	input logic        rd_n,
	input logic        wr_n,
	input logic        port_wr,
	input logic        dataout,
	input logic        ay_bdir,
	input logic        lock48,  // 7FFD bit 5
	input logic        block1m, // EFF7 bit 2
	input logic [7:0]  p7ffd
);

	logic fd_wr; // 7FFD write strobe seen on the bus

	assign fd_wr = port_wr & (a[7:0] == `ZP_PORT_FD) & ~a[15];

	// one pulse per cycle, never back to back
	a_wr_single: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr |=> !port_wr)
		else $error("port_wr high on two consecutive cycles");

	a_oe_read: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout |-> (!iorq_n && !rd_n))
		else $error("dataout outside an io read cycle");

	a_bdir_wr: assert property (@(posedge zclk) disable iff (!rst_n)
		ay_bdir |-> !wr_n)
		else $error("ay_bdir without wr_n low");

	// locked 48K mode ignores 7FFD writes
	a_lock_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		(lock48 && block1m && fd_wr) |=> $stable(p7ffd))
		else $error("p7ffd changed while locked");

endmodule

bind zports_top zports_props u_props (
	.zclk    (zclk),
	.rst_n   (rst_n),
	.a       (a),
	.iorq_n  (iorq_n),
	.rd_n    (rd_n),
	.wr_n    (wr_n),
	.port_wr (bus.port_wr),
	.dataout (dataout),
	.ay_bdir (ay_bdir),
	.lock48  (p7ffd_reg.fld.lock48),
	.block1m (peff7_reg[2]),
	.p7ffd   (p7ffd)
);

// File: test/tb_zports.sv
// testbench for the CPU I/O port block
// clock, reset, directed test tasks and summary

`timescale 1ns/1ps

module tb_zports;

	localparam int MAX_CYCLES = 2000; // tests need roughly 300 cycles

	logic        zclk, rst_n;
	logic [15:0] a;
	logic [7:0]  din, dout;
	logic        dataout, iorq_n, rd_n, wr_n, dos;
	logic [4:0]  keys_in, kj_in;
	logic [7:0]  mus_in;
	logic        tape_read, porthit, external_port;
	logic [3:0]  border;
	logic        beeper_wr, ay_bdir, ay_bc1, romrw_en, set_nmi, clr_nmi;
	logic [7:0]  p7ffd, peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom, pent1m_1m_on, pent1m_ram0_0;

	int errors   = 0;
	int checks   = 0;
	int beep_cnt = 0; // beeper_wr pulses seen
	int clr_cnt  = 0; // clr_nmi pulses seen
	int cycles   = 0;

	zports_top dut (.*);

	initial
	begin
		zclk = 1'b0;
		forever #5 zclk = ~zclk;
	end

	// pulses counted mid-cycle away from the clock edge
	always @(negedge zclk)
	begin
		if (beeper_wr)
			beep_cnt++;
		if (clr_nmi)
			clr_cnt++;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////////////////////////////////////////

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge zclk);
		#1;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (4) @(posedge zclk);
		#1;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(posedge zclk);
	endtask

	// starts a cycle and stops in the middle of its second clock
	task automatic probe_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic is_wr);
		@(posedge zclk);
		#1;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = ~is_wr;
		rd_n   = is_wr;
		@(posedge zclk);
		@(negedge zclk);
	endtask

	task automatic end_cycle;
		@(posedge zclk);
		#1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		@(posedge zclk);
	endtask

	task automatic io_read(input logic [15:0] addr, input logic [7:0] expected);
		probe_cycle(addr, 8'h00, 1'b0);
		check_value("dout", dout, expected);
		check_value("porthit", porthit, 1'b1);
		check_value("dataout", dataout, 1'b1);
		end_cycle;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset;
		check_value("p7ffd", p7ffd, 8'h00);
		check_value("peff7", peff7, 8'h00);
		check_value("pent1m_page", pent1m_page, 6'h00);
		check_value("pent1m_rom", pent1m_rom, 1'b0);
		check_value("pent1m_1m_on", pent1m_1m_on, 1'b1); // EFF7 bit 2 clear
		check_value("border", border, 4'h0);
		check_value("romrw_en", romrw_en, 1'b0);
		check_value("set_nmi", set_nmi, 1'b0);
		check_value("ay_bc1", ay_bc1, 1'b0); // bus idle
		check_value("ay_bdir", ay_bdir, 1'b0);
	endtask

	task automatic test_paging;
		io_write(16'h7FFD, 8'h17);
		check_value("p7ffd", p7ffd, 8'h17);
		check_value("pent1m_page", pent1m_page, 6'h07); // ram page 7
		check_value("pent1m_rom", pent1m_rom, 1'b1);
		io_write(16'h7FFD, 8'hC5);
		check_value("pent1m_page", pent1m_page, 6'h35); // ext page 3 over ram page 5
		io_write(16'h01F7, 8'h04); // block-1M on
		check_value("p7ffd", p7ffd, 8'h05); // bits 7..5 masked
		io_write(16'h7FFD, 8'h3A); // lock48 set but this one still loads
		check_value("p7ffd", p7ffd, 8'h1A);
		io_write(16'h7FFD, 8'h01); // locked now
		check_value("p7ffd", p7ffd, 8'h1A);
		check_value("pent1m_page", pent1m_page, 6'h0A);
		io_write(16'h01F7, 8'h00);
		io_write(16'h7FFD, 8'h00);
		check_value("p7ffd", p7ffd, 8'h00);
	endtask

	task automatic test_eff7_shadow;
		io_write(16'h01F7, 8'h89);
		check_value("peff7", peff7, 8'h89);
		check_value("pent1m_1m_on", pent1m_1m_on, 1'b1);
		check_value("pent1m_ram0_0", pent1m_ram0_0, 1'b1);
		io_write(16'h01F7, 8'h0C); // bits 6,3,2,1 masked in block-1M
		check_value("peff7", peff7, 8'h00);
		check_value("pent1m_1m_on", pent1m_1m_on, 1'b0);
		@(posedge zclk);
		#1;
		dos = 1'b1;
		io_write(16'h01F7, 8'h00); // ignored in shadow mode
		check_value("pent1m_1m_on", pent1m_1m_on, 1'b0);
		check_value("pent1m_ram0_0", pent1m_ram0_0, 1'b1);
		probe_cycle(16'h001F, 8'h00, 1'b0);
		check_value("porthit", porthit, 1'b0);
		check_value("dataout", dataout, 1'b0);
		end_cycle;
		#1;
		dos = 1'b0;
		io_write(16'h11F7, 8'h00); // a12 high so not EFF7
		check_value("pent1m_1m_on", pent1m_1m_on, 1'b0);
		io_write(16'h01F7, 8'h00);
		check_value("pent1m_1m_on", pent1m_1m_on, 1'b1);
	endtask

	task automatic test_fe_port;
		int         b0;
		logic [4:0] keys;
		logic [4:0] joy;
		logic [7:0] mouse;
		keys  = $urandom;
		joy   = $urandom;
		mouse = $urandom;
		b0    = beep_cnt;
		io_write(16'h00FE, 8'h05); // a3 set so border bit 3 clear
		check_value("border", border, 4'h5);
		check_value("beeper_wr pulses", beep_cnt - b0, 1);
		io_write(16'h00F6, 8'hFB); // a3 clear and no beeper on F6
		check_value("border", border, 4'hB);
		check_value("beeper_wr pulses", beep_cnt - b0, 1);
		@(posedge zclk);
		#1;
		keys_in   = keys;
		kj_in     = joy;
		mus_in    = mouse;
		tape_read = 1'b1;
		io_read(16'h00FE, {1'b1, 1'b1, 1'b0, keys});
		io_read(16'h00DF, mouse);
		io_read(16'h001F, {3'b000, joy});
	endtask

	task automatic test_cfg_ports;
		int c0;
		io_write(16'h00BF, 8'h0A); // rom write enable and nmi request
		check_value("romrw_en", romrw_en, 1'b1);
		check_value("set_nmi", set_nmi, 1'b1);
		io_read(16'h00BF, 8'h0A);
		c0 = clr_cnt;
		io_write(16'h00BE, 8'h00);
		check_value("clr_nmi pulses", clr_cnt - c0, 1);
		io_write(16'h7FFD, 8'h2C);
		io_write(16'h01F7, 8'h81);
		io_read(16'h0ABE, 8'h2C); // index A
		io_read(16'h0BBE, 8'h81); // index B
		io_read(16'h05BE, 8'hFF);
		io_write(16'h00BF, 8'h00);
		check_value("romrw_en", romrw_en, 1'b0);
		check_value("set_nmi", set_nmi, 1'b0);
	endtask

	task automatic test_ay_ctrl;
		probe_cycle(16'hFFFD, 8'h00, 1'b0); // register read
		check_value("ay_bc1", ay_bc1, 1'b1);
		check_value("ay_bdir", ay_bdir, 1'b0);
		check_value("external_port", external_port, 1'b1);
		check_value("dataout", dataout, 1'b0);
		end_cycle;
		probe_cycle(16'hFFFD, 8'h07, 1'b1); // address latch
		check_value("ay_bc1", ay_bc1, 1'b1);
		check_value("ay_bdir", ay_bdir, 1'b1);
		check_value("external_port", external_port, 1'b1);
		end_cycle;
		probe_cycle(16'hBFFD, 8'h55, 1'b1); // data write
		check_value("ay_bc1", ay_bc1, 1'b0);
		check_value("ay_bdir", ay_bdir, 1'b1);
		check_value("external_port", external_port, 1'b0);
		end_cycle;
		check_value("p7ffd", p7ffd, 8'h2C); // a15 high so no paging
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = 5'h1F;
		kj_in     = 5'h00;
		mus_in    = 8'hFF;
		tape_read = 1'b0;
		rst_n     = 1'b0;
		void'($urandom(32'hd53a729e));
		repeat (8) @(posedge zclk);
		#1;
		rst_n = 1'b1;
		@(posedge zclk);
		test_reset;
		test_paging;
		test_eff7_shadow;
		test_fe_port;
		test_cfg_ports;
		test_ay_ctrl;
		$display("summary: %0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog
	initial
	begin
		while (cycles < MAX_CYCLES)
		begin
			@(posedge zclk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+common
common/zports_pkg.sv
common/io_bus_if.sv
hw/io_strobe.sv
hw/port_decode.sv
hw/sys_ports.sv
paging/mem_paging.sv
hw/zports_top.sv
test/zports_props.sv
test/tb_zports.sv

// File: Bender.yml
package:
  name: zports

sources:
  - include_dirs:
      - common
    files:
      - common/zports_pkg.sv
      - common/io_bus_if.sv
      - hw/io_strobe.sv
      - hw/port_decode.sv
      - hw/sys_ports.sv
      - paging/mem_paging.sv
      - hw/zports_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/zports_props.sv
      - test/tb_zports.sv
